// File: iommu_reg_top.f
verilog/iommu_field_pkg.sv
verilog/iommu_field_arb.sv
verilog/iommu_field_reg.sv
verilog/iommu_reg_decode.sv
verilog/iommu_reg_bank.sv
verilog/iommu_reg_respond.sv
verilog/iommu_reg_top.sv
testbench/iommu_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the register block testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module iommu_reg_tb \
    -f iommu_reg_top.f -o iommu_reg_sim > build.log 2>&1 \
    && ./obj_dir/iommu_reg_sim > sim.log 2>&1 \
    && grep -qx "Test passed" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/iommu_reg_tb.sv
// Directed testbench for the IOMMU register block.
// Drives the register bus and the hardware event ports of the top level and
// checks every response against a reference model of the register map.
// The model follows the access rules of each field, one register per type.

`timescale 1ns/1ns
`default_nettype none

module iommu_reg_tb;

    import iommu_field_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  req;
    logic                  req_write;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic                  resp;
    logic [DATA_WIDTH-1:0] resp_rdata;
    logic                  resp_error;
    logic                  ctrl_de;
    logic [DATA_WIDTH-1:0] ctrl_d;
    logic                  status_de;
    logic [DATA_WIDTH-1:0] status_d;
    logic [DATA_WIDTH-1:0] fault_set;
    logic [DATA_WIDTH-1:0] irq_clr;
    logic [DATA_WIDTH-1:0] doorbell_set;
    logic                  err_event;
    logic [DATA_WIDTH-1:0] ctrl_q;
    logic [DATA_WIDTH-1:0] fault_q;
    logic [DATA_WIDTH-1:0] irq_pend_q;
    logic [DATA_WIDTH-1:0] doorbell_q;

    // Reference copy of the register map, indexed like the one-hot select.
    logic [DATA_WIDTH-1:0] model [0:NUM_REGS-1];
    integer                seed;
    int                    checks;
    int                    errors;
    string                 test_name;

    iommu_reg_top uut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .resp         (resp),
        .resp_rdata   (resp_rdata),
        .resp_error   (resp_error),
        .ctrl_de      (ctrl_de),
        .ctrl_d       (ctrl_d),
        .status_de    (status_de),
        .status_d     (status_d),
        .fault_set    (fault_set),
        .irq_clr      (irq_clr),
        .doorbell_set (doorbell_set),
        .err_event    (err_event),
        .ctrl_q       (ctrl_q),
        .fault_q      (fault_q),
        .irq_pend_q   (irq_pend_q),
        .doorbell_q   (doorbell_q)
    );

    // 10 ns clock period.
    always #5 clk = ~clk;

    // Register index for a bus address, or -1 when nothing is mapped there.
    function automatic int index_of(input logic [ADDR_WIDTH-1:0] addr);
        case (addr)
            CTRL_OFFSET:     return CTRL_IDX;
            STATUS_OFFSET:   return STATUS_IDX;
            FAULT_OFFSET:    return FAULT_IDX;
            IRQ_PEND_OFFSET: return IRQ_PEND_IDX;
            DOORBELL_OFFSET: return DOORBELL_IDX;
            ERR_CNT_OFFSET:  return ERR_CNT_IDX;
            default:         return -1;
        endcase
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] addr_of(input int idx);
        case (idx)
            CTRL_IDX:     return CTRL_OFFSET;
            STATUS_IDX:   return STATUS_OFFSET;
            FAULT_IDX:    return FAULT_OFFSET;
            IRQ_PEND_IDX: return IRQ_PEND_OFFSET;
            DOORBELL_IDX: return DOORBELL_OFFSET;
            default:      return ERR_CNT_OFFSET;
        endcase
    endfunction

    // Value of a register after a software write, by its access type.
    // Status and the error count ignore software writes.
    function automatic logic [DATA_WIDTH-1:0] after_write(input int idx,
            input logic [DATA_WIDTH-1:0] cur, input logic [DATA_WIDTH-1:0] wd);
        case (idx)
            CTRL_IDX:     return wd;
            FAULT_IDX:    return cur & ~wd;
            IRQ_PEND_IDX: return cur | wd;
            DOORBELL_IDX: return cur & wd;
            default:      return cur;
        endcase
    endfunction

    task automatic compare(input string what, input logic [DATA_WIDTH-1:0] expected,
                           input logic [DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // Applies one request to the model and returns what the bus should answer.
    // A read of the error count clears it after its value is returned.
    task automatic predict(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] wdata,
                           output logic [DATA_WIDTH-1:0] exp_rdata, output logic exp_err);
        int idx;
        idx       = index_of(addr);
        exp_rdata = '0;
        exp_err   = (idx < 0);
        if (idx >= 0) begin
            if (write) begin
                model[idx] = after_write(idx, model[idx], wdata);
            end else begin
                exp_rdata = model[idx];
                if (idx == ERR_CNT_IDX)
                    model[idx] = '0;
            end
        end
    endtask

    // One bus request, then a bounded wait for its response.
    task automatic bus_access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata);
        logic [DATA_WIDTH-1:0] exp_rdata;
        logic                  exp_err;
        int                    cycles;
        logic                  got;
        predict(write, addr, wdata, exp_rdata, exp_err);
        @(posedge clk);
        req       <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);
        req    <= 1'b0;
        cycles = 0;
        got    = 1'b0;
        // Give up after 20 cycles.
        while (!got && cycles < 20) begin
            @(negedge clk);
            cycles++;
            got = resp;
        end
        if (!got) begin
            errors++;
            $display("ERROR: %s: no response to address %h within 20 cycles", test_name, addr);
        end else begin
            compare("latency", 32'd2, 32'(cycles));
            compare("resp_rdata", exp_rdata, resp_rdata);
            compare("resp_error", 32'(exp_err), 32'(resp_error));
        end
    endtask

    task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata);
        bus_access(1'b1, addr, wdata);
    endtask

    task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr);
        bus_access(1'b0, addr, '0);
    endtask

    // One cycle of a hardware event on the port of register idx.
    // The update lands at the edge that ends the pulse.
    task automatic hw_event(input int idx, input logic [DATA_WIDTH-1:0] value);
        @(posedge clk);
        case (idx)
            CTRL_IDX: begin
                ctrl_de <= 1'b1;
                ctrl_d  <= value;
            end
            STATUS_IDX: begin
                status_de <= 1'b1;
                status_d  <= value;
            end
            FAULT_IDX:    fault_set    <= value;
            IRQ_PEND_IDX: irq_clr      <= value;
            DOORBELL_IDX: doorbell_set <= value;
            default:      err_event    <= 1'b1;
        endcase
        @(posedge clk);
        ctrl_de      <= 1'b0;
        status_de    <= 1'b0;
        fault_set    <= '0;
        irq_clr      <= '0;
        doorbell_set <= '0;
        err_event    <= 1'b0;
        case (idx)
            CTRL_IDX, STATUS_IDX: model[idx] = value;
            FAULT_IDX:            model[idx] = model[idx] | value;
            IRQ_PEND_IDX:         model[idx] = model[idx] & ~value;
            DOORBELL_IDX:         model[idx] = model[idx] | value;
            // Saturating counter.
            default: if (model[idx] != '1) model[idx] = model[idx] + 32'd1;
        endcase
        @(negedge clk);
    endtask

    task automatic check_outputs();
        compare("ctrl_q", model[CTRL_IDX], ctrl_q);
        compare("fault_q", model[FAULT_IDX], fault_q);
        compare("irq_pend_q", model[IRQ_PEND_IDX], irq_pend_q);
        compare("doorbell_q", model[DOORBELL_IDX], doorbell_q);
    endtask

    task automatic read_all();
        for (int idx = 0; idx < NUM_REGS; idx++)
            bus_read(addr_of(idx));
    endtask

    task automatic test_reset_rw();
        test_name = "reset_rw";
        read_all();
        check_outputs();
        repeat (4) begin
            bus_write(CTRL_OFFSET, $random(seed));
            bus_read(CTRL_OFFSET);
        end
        hw_event(CTRL_IDX, $random(seed));
        check_outputs();
        bus_read(CTRL_OFFSET);
    endtask

    task automatic test_ro_rc();
        int n;
        test_name = "ro_rc";
        hw_event(STATUS_IDX, $random(seed));
        bus_read(STATUS_OFFSET);
        bus_write(STATUS_OFFSET, $random(seed));
        bus_read(STATUS_OFFSET);
        // The first read returns the event count, the second finds it cleared.
        n = 3 + ($random(seed) & 3);
        repeat (n) hw_event(ERR_CNT_IDX, '0);
        bus_read(ERR_CNT_OFFSET);
        bus_read(ERR_CNT_OFFSET);
    endtask

    task automatic test_w1c_w1s();
        test_name = "w1c_w1s";
        hw_event(FAULT_IDX, $random(seed));
        check_outputs();
        bus_write(FAULT_OFFSET, $random(seed));
        check_outputs();
        bus_read(FAULT_OFFSET);
        bus_write(FAULT_OFFSET, '1);
        bus_read(FAULT_OFFSET);
        bus_write(IRQ_PEND_OFFSET, $random(seed));
        check_outputs();
        hw_event(IRQ_PEND_IDX, $random(seed));
        check_outputs();
        bus_read(IRQ_PEND_OFFSET);
    endtask

    task automatic test_w0c();
        test_name = "w0c";
        hw_event(DOORBELL_IDX, $random(seed));
        check_outputs();
        bus_write(DOORBELL_OFFSET, $random(seed));
        check_outputs();
        bus_read(DOORBELL_OFFSET);
    endtask

    // Eight requests on consecutive cycles. Request i must answer in the
    // cycle of loop pass i + 2, which checks order and latency together.
    task automatic test_pipeline();
        logic [ADDR_WIDTH-1:0] addrs [0:7];
        logic                  writes [0:7];
        logic [DATA_WIDTH-1:0] wdata [0:7];
        logic [DATA_WIDTH-1:0] exp_rdata [0:7];
        logic                  exp_err [0:7];
        test_name = "pipeline";
        addrs = '{CTRL_OFFSET, CTRL_OFFSET, 8'h18, IRQ_PEND_OFFSET,
                  IRQ_PEND_OFFSET, 8'h06, STATUS_OFFSET, STATUS_OFFSET};
        writes = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
        for (int i = 0; i < 8; i++) begin
            wdata[i] = $random(seed);
            predict(writes[i], addrs[i], wdata[i], exp_rdata[i], exp_err[i]);
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i < 8) begin
                req       <= 1'b1;
                req_write <= writes[i];
                req_addr  <= addrs[i];
                req_wdata <= wdata[i];
            end else begin
                req <= 1'b0;
            end
            @(negedge clk);
            compare("resp", (i >= 2) ? 32'd1 : 32'd0, 32'(resp));
            if (i >= 2) begin
                compare("resp_rdata", exp_rdata[i-2], resp_rdata);
                compare("resp_error", 32'(exp_err[i-2]), 32'(resp_error));
            end
        end
        // The unmapped requests must have left every register alone.
        read_all();
        check_outputs();
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        req          = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        ctrl_de      = 1'b0;
        ctrl_d       = '0;
        status_de    = 1'b0;
        status_d     = '0;
        fault_set    = '0;
        irq_clr      = '0;
        doorbell_set = '0;
        err_event    = 1'b0;
        seed         = 32'h20c9ed5f;
        checks       = 0;
        errors       = 0;
        model = '{CTRL_RESET, STATUS_RESET, FAULT_RESET,
                  IRQ_PEND_RESET, DOORBELL_RESET, ERR_CNT_RESET};
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset_rw();
        test_ro_rc();
        test_w1c_w1s();
        test_w0c();
        test_pipeline();
        repeat (2) @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/iommu_reg_top.sv
// Top level of the IOMMU register block.
// Chains decode, bank and response stages; a request gets its response two
// cycles later. Hardware event ports go straight to the bank.

`timescale 1ns/1ns
`default_nettype none

module iommu_reg_top (
    input  logic                                  clk,
    input  logic                                  reset,
    // Register bus.
    input  logic                                  req,
    input  logic                                  req_write,
    input  logic [iommu_field_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] req_wdata,
    output logic                                  resp,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] resp_rdata,
    output logic                                  resp_error,
    // Hardware events and register views.
    input  logic                                  ctrl_de,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] ctrl_d,
    input  logic                                  status_de,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] status_d,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] fault_set,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] irq_clr,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] doorbell_set,
    input  logic                                  err_event,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] ctrl_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] fault_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] irq_pend_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] doorbell_q
);

    import iommu_field_pkg::*;

    // Stage 1 outputs, shared by the bank and the response stage.
    logic                  s1_valid;
    logic                  s1_write;
    logic [NUM_REGS-1:0]   s1_sel;
    logic [DATA_WIDTH-1:0] s1_wdata;
    logic                  s1_error;
    // Registers that are only seen through the bus.
    logic [DATA_WIDTH-1:0] status_q;
    logic [DATA_WIDTH-1:0] err_cnt_q;

    iommu_reg_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .s1_valid  (s1_valid),
        .s1_write  (s1_write),
        .s1_sel    (s1_sel),
        .s1_wdata  (s1_wdata),
        .s1_error  (s1_error)
    );

    iommu_reg_bank u_bank (
        .clk          (clk),
        .reset        (reset),
        .s1_valid     (s1_valid),
        .s1_write     (s1_write),
        .s1_sel       (s1_sel),
        .s1_wdata     (s1_wdata),
        .ctrl_de      (ctrl_de),
        .ctrl_d       (ctrl_d),
        .status_de    (status_de),
        .status_d     (status_d),
        .fault_set    (fault_set),
        .irq_clr      (irq_clr),
        .doorbell_set (doorbell_set),
        .err_event    (err_event),
        .ctrl_q       (ctrl_q),
        .status_q     (status_q),
        .fault_q      (fault_q),
        .irq_pend_q   (irq_pend_q),
        .doorbell_q   (doorbell_q),
        .err_cnt_q    (err_cnt_q)
    );

    iommu_reg_respond u_respond (
        .clk        (clk),
        .reset      (reset),
        .s1_valid   (s1_valid),
        .s1_write   (s1_write),
        .s1_sel     (s1_sel),
        .s1_error   (s1_error),
        .ctrl_q     (ctrl_q),
        .status_q   (status_q),
        .fault_q    (fault_q),
        .irq_pend_q (irq_pend_q),
        .doorbell_q (doorbell_q),
        .err_cnt_q  (err_cnt_q),
        .resp       (resp),
        .resp_rdata (resp_rdata),
        .resp_error (resp_error)
    );

endmodule

`default_nettype wire

// File: verilog/iommu_reg_respond.sv
// Stage 3 of the register pipeline.
// Registers one bus response per valid stage 1 request, with the selected
// register value for reads and the decode error flag.

`timescale 1ns/1ns
`default_nettype none

module iommu_reg_respond (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  s1_valid,
    input  logic                                  s1_write,
    input  logic [iommu_field_pkg::NUM_REGS-1:0]   s1_sel,
    input  logic                                  s1_error,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] ctrl_q,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] status_q,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] fault_q,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] irq_pend_q,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] doorbell_q,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] err_cnt_q,
    output logic                                  resp,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] resp_rdata,
    output logic                                  resp_error
);

    import iommu_field_pkg::*;

    logic [DATA_WIDTH-1:0] rdata_next;

    // AND-OR multiplexer over the one-hot select.
    // An error has an empty select, so it returns zero like a write does.
    always_comb begin
        rdata_next = '0;
        if (s1_valid && !s1_write) begin
            rdata_next = ({DATA_WIDTH{s1_sel[CTRL_IDX]}}     & ctrl_q)
                       | ({DATA_WIDTH{s1_sel[STATUS_IDX]}}   & status_q)
                       | ({DATA_WIDTH{s1_sel[FAULT_IDX]}}    & fault_q)
                       | ({DATA_WIDTH{s1_sel[IRQ_PEND_IDX]}} & irq_pend_q)
                       | ({DATA_WIDTH{s1_sel[DOORBELL_IDX]}} & doorbell_q)
                       | ({DATA_WIDTH{s1_sel[ERR_CNT_IDX]}}  & err_cnt_q);
        end
    end

    // Sampling at the same edge the bank writes means a read returns the
    // value from before that edge, which for RC is the value before the clear.
    always_ff @(posedge clk) begin
        if (reset) begin
            resp       <= 1'b0;
            resp_error <= 1'b0;
        end else begin
            resp       <= s1_valid;
            resp_error <= s1_valid && s1_error;
        end
    end

    always_ff @(posedge clk) begin
        resp_rdata <= rdata_next;
    end

endmodule

`default_nettype wire

// File: verilog/iommu_reg_bank.sv
// Stage 2 of the register pipeline.
// Holds the six register fields of the map and forms their software strobes
// from the stage 1 request and their hardware updates from the event ports.

`timescale 1ns/1ns
`default_nettype none

module iommu_reg_bank (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  s1_valid,
    input  logic                                  s1_write,
    input  logic [iommu_field_pkg::NUM_REGS-1:0]   s1_sel,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] s1_wdata,
    input  logic                                  ctrl_de,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] ctrl_d,
    input  logic                                  status_de,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] status_d,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] fault_set,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] irq_clr,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] doorbell_set,
    input  logic                                  err_event,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] ctrl_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] status_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] fault_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] irq_pend_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] doorbell_q,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] err_cnt_q
);

    import iommu_field_pkg::*;

    logic                  sw_wr;
    logic                  sw_rd;
    logic [NUM_REGS-1:0]   we;
    logic [DATA_WIDTH-1:0] fault_d;
    logic [DATA_WIDTH-1:0] irq_pend_d;
    logic [DATA_WIDTH-1:0] doorbell_d;
    logic [DATA_WIDTH-1:0] err_cnt_d;

    // A register sees a software write when it is selected by a valid write.
    // The error count is read-to-clear, so its strobe comes from reads.
    assign sw_wr = s1_valid && s1_write;
    assign sw_rd = s1_valid && !s1_write;

    assign we[CTRL_IDX]     = sw_wr && s1_sel[CTRL_IDX];
    assign we[STATUS_IDX]   = sw_wr && s1_sel[STATUS_IDX];
    assign we[FAULT_IDX]    = sw_wr && s1_sel[FAULT_IDX];
    assign we[IRQ_PEND_IDX] = sw_wr && s1_sel[IRQ_PEND_IDX];
    assign we[DOORBELL_IDX] = sw_wr && s1_sel[DOORBELL_IDX];
    assign we[ERR_CNT_IDX]  = sw_rd && s1_sel[ERR_CNT_IDX];

    // Hardware updates are built on the current value.
    // The arbiter then applies the software mask on top of them.
    assign fault_d    = fault_q | fault_set;
    assign irq_pend_d = irq_pend_q & ~irq_clr;
    assign doorbell_d = doorbell_q | doorbell_set;
    // The counter sticks at all ones instead of wrapping to zero.
    assign err_cnt_d  = (err_cnt_q == '1) ? err_cnt_q : err_cnt_q + 1'b1;

    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessRW), .ResetVal (CTRL_RESET)
    ) u_ctrl (
        .clk (clk), .reset (reset), .we (we[CTRL_IDX]), .wd (s1_wdata),
        .de (ctrl_de), .d (ctrl_d), .q (ctrl_q)
    );

    // Status software writes are passed in and dropped by the RO arbiter.
    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessRO), .ResetVal (STATUS_RESET)
    ) u_status (
        .clk (clk), .reset (reset), .we (we[STATUS_IDX]), .wd (s1_wdata),
        .de (status_de), .d (status_d), .q (status_q)
    );

    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessW1C), .ResetVal (FAULT_RESET)
    ) u_fault (
        .clk (clk), .reset (reset), .we (we[FAULT_IDX]), .wd (s1_wdata),
        .de (|fault_set), .d (fault_d), .q (fault_q)
    );

    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessW1S), .ResetVal (IRQ_PEND_RESET)
    ) u_irq_pend (
        .clk (clk), .reset (reset), .we (we[IRQ_PEND_IDX]), .wd (s1_wdata),
        .de (|irq_clr), .d (irq_pend_d), .q (irq_pend_q)
    );

    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessW0C), .ResetVal (DOORBELL_RESET)
    ) u_doorbell (
        .clk (clk), .reset (reset), .we (we[DOORBELL_IDX]), .wd (s1_wdata),
        .de (|doorbell_set), .d (doorbell_d), .q (doorbell_q)
    );

    // Read-to-clear counter, an increment in the clearing cycle is lost.
    iommu_field_reg #(
        .DW (DATA_WIDTH), .SwAccess (SwAccessRC), .ResetVal (ERR_CNT_RESET)
    ) u_err_cnt (
        .clk (clk), .reset (reset), .we (we[ERR_CNT_IDX]), .wd (s1_wdata),
        .de (err_event), .d (err_cnt_d), .q (err_cnt_q)
    );

endmodule

`default_nettype wire

// File: verilog/iommu_reg_decode.sv
// Stage 1 of the register pipeline.
// Registers each bus request and turns its address into a one-hot register
// select, or an error flag for an address outside the map.

`timescale 1ns/1ns
`default_nettype none

module iommu_reg_decode (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req,
    input  logic                                  req_write,
    input  logic [iommu_field_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [iommu_field_pkg::DATA_WIDTH-1:0] req_wdata,
    output logic                                  s1_valid,
    output logic                                  s1_write,
    output logic [iommu_field_pkg::NUM_REGS-1:0]   s1_sel,
    output logic [iommu_field_pkg::DATA_WIDTH-1:0] s1_wdata,
    output logic                                  s1_error
);

    import iommu_field_pkg::*;

    logic [NUM_REGS-1:0] sel_next;
    logic                error_next;

    // The full byte address is compared, so a misaligned address matches no
    // offset and falls into the error case along with unmapped ones.
    always_comb begin
        sel_next = '0;
        case (req_addr)
            CTRL_OFFSET:     sel_next[CTRL_IDX]     = 1'b1;
            STATUS_OFFSET:   sel_next[STATUS_IDX]   = 1'b1;
            FAULT_OFFSET:    sel_next[FAULT_IDX]    = 1'b1;
            IRQ_PEND_OFFSET: sel_next[IRQ_PEND_IDX] = 1'b1;
            DOORBELL_OFFSET: sel_next[DOORBELL_IDX] = 1'b1;
            ERR_CNT_OFFSET:  sel_next[ERR_CNT_IDX]  = 1'b1;
            default:         sel_next = '0;
        endcase
        // An error is only flagged for a real request.
        error_next = req && (sel_next == '0);
    end

    // Control fields of the stage. The select is cleared when there is no
    // request, so the bank never sees a stale register choice.
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_write <= 1'b0;
            s1_sel   <= '0;
            s1_error <= 1'b0;
        end else begin
            s1_valid <= req;
            s1_write <= req && req_write;
            s1_sel   <= req ? sel_next : '0;
            s1_error <= error_next;
        end
    end

    // Write data is payload and only matters alongside s1_write.
    always_ff @(posedge clk) begin
        s1_wdata <= req_wdata;
    end

endmodule

`default_nettype wire

// File: verilog/iommu_field_reg.sv
// One software-visible register field.
// A word of flip-flops with a reset value, written through its own arbiter.
// The bank instantiates one per register with its access type.

`timescale 1ns/1ns
`default_nettype none

module iommu_field_reg #(
    parameter int                          DW       = 32,
    parameter iommu_field_pkg::sw_access_e SwAccess = iommu_field_pkg::SwAccessRW,
    parameter logic [DW-1:0]               ResetVal = '0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          we,
    input  logic [DW-1:0] wd,
    input  logic          de,
    input  logic [DW-1:0] d,
    output logic [DW-1:0] q
);

    logic          wr_en;
    logic [DW-1:0] wr_data;

    // The arbiter sees the stored value so it can do bitwise set and clear.
    iommu_field_arb #(
        .DW       (DW),
        .SwAccess (SwAccess)
    ) u_arb (
        .we      (we),
        .wd      (wd),
        .de      (de),
        .d       (d),
        .q       (q),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    // The word keeps its value unless the arbiter asks for a write.
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= ResetVal;
        end else if (wr_en) begin
            q <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/iommu_field_arb.sv
// Write arbiter for one register field.
// Merges a software access and a hardware update into a single write enable
// and write data word, according to the field's software access type.
// Purely combinational; the field register instantiates it.

`timescale 1ns/1ns
`default_nettype none

module iommu_field_arb #(
    parameter int                         DW       = 32,
    parameter iommu_field_pkg::sw_access_e SwAccess = iommu_field_pkg::SwAccessRW
) (
    // Software side. For RC the bank drives we with the read strobe.
    input  logic          we,
    input  logic [DW-1:0] wd,

    // Hardware side, an update strobe and its value.
    input  logic          de,
    input  logic [DW-1:0] d,

    // Current register value, needed for the bitwise set and clear types.
    input  logic [DW-1:0] q,

    // Resolved write to the register.
    output logic          wr_en,
    output logic [DW-1:0] wr_data
);

    import iommu_field_pkg::*;

    if (SwAccess == SwAccessRW) begin : gen_rw
        // Both sides may write the whole word.
        // Software takes priority when both write in the same cycle.
        assign wr_en   = we | de;
        assign wr_data = we ? wd : d;
    end else if (SwAccess == SwAccessRO) begin : gen_ro
        // Software cannot change the field, so only hardware writes it.
        assign wr_en   = de;
        assign wr_data = d;
    end else if (SwAccess == SwAccessW1S) begin : gen_w1s
        // Hardware is expected to clear bits here.
        // Bits written as 1 are set on top of the hardware value, so software
        // wins where both touch the same bit.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) | (we ? wd : '0);
    end else if (SwAccess == SwAccessW1C) begin : gen_w1c
        // Hardware is expected to set bits here.
        // Bits written as 1 are cleared after the hardware value is applied,
        // so a clear from software wins over a set in the same cycle.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) & (we ? ~wd : '1);
    end else if (SwAccess == SwAccessW0C) begin : gen_w0c
        // Same as W1C but with the mask inverted.
        // Only the bits written as 0 are cleared.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) & (we ? wd : '1);
    end else if (SwAccess == SwAccessRC) begin : gen_rc
        // Here we is the read strobe, and a read clears the whole word.
        // A hardware update in the same cycle as the read is dropped.
        assign wr_en   = we | de;
        assign wr_data = we ? '0 : d;
    end else begin : gen_hw
        // Hardware-only field, software has no way in.
        assign wr_en   = de;
        assign wr_data = d;
    end

endmodule

`default_nettype wire

// File: verilog/iommu_field_pkg.sv
// Shared definitions for the IOMMU register block.
// Holds the software access types, bus widths, the register map and the
// reset values. Modules import it inside their bodies.

`default_nettype none

package iommu_field_pkg;

    // Software access types that a register field can take.
    // HW marks a field that only hardware may write.
    typedef enum logic [2:0] {
        SwAccessRW,
        SwAccessRO,
        SwAccessW1S,
        SwAccessW1C,
        SwAccessW0C,
        SwAccessRC,
        SwAccessHW
    } sw_access_e;

    // Bus and register widths.
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;

    // Number of registers in the map, which is also the width of the select.
    localparam int NUM_REGS = 6;

    // Byte offsets of the registers on the bus.
    localparam logic [ADDR_WIDTH-1:0] CTRL_OFFSET     = 8'h00;
    localparam logic [ADDR_WIDTH-1:0] STATUS_OFFSET   = 8'h04;
    localparam logic [ADDR_WIDTH-1:0] FAULT_OFFSET    = 8'h08;
    localparam logic [ADDR_WIDTH-1:0] IRQ_PEND_OFFSET = 8'h0C;
    localparam logic [ADDR_WIDTH-1:0] DOORBELL_OFFSET = 8'h10;
    localparam logic [ADDR_WIDTH-1:0] ERR_CNT_OFFSET  = 8'h14;

    // Bit positions of each register in the one-hot select.
    localparam int CTRL_IDX     = 0;
    localparam int STATUS_IDX   = 1;
    localparam int FAULT_IDX    = 2;
    localparam int IRQ_PEND_IDX = 3;
    localparam int DOORBELL_IDX = 4;
    localparam int ERR_CNT_IDX  = 5;

    // Reset values. Control comes up with its enable bit set.
    localparam logic [DATA_WIDTH-1:0] CTRL_RESET     = 32'h0000_0001;
    localparam logic [DATA_WIDTH-1:0] STATUS_RESET   = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] FAULT_RESET    = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] IRQ_PEND_RESET = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] DOORBELL_RESET = 32'h0000_0000;
    localparam logic [DATA_WIDTH-1:0] ERR_CNT_RESET  = 32'h0000_0000;

endpackage

`default_nettype wire
